/* regs_pkg.sv */
package regs_pkg;

    // special upper nibbles of a register code
    // current bank, i.e. the bank rfp points at
    localparam logic [3:0] TAG_CUR  = 4'he;
    // previous bank, rfp minus one, wraps 0 -> 3
    localparam logic [3:0] TAG_PREV = 4'hd;
    // pointer group, not banked
    localparam logic [3:0] TAG_PTR  = 4'hf;

    // one register code byte, two decodings of the same bits
    // acc view when the top nibble is anything but F
    // ptr view when the top nibble is F
    typedef union packed {
        struct packed {
            // page bits, ignored once the tag is resolved
            logic [1:0] page;
            // bank 0..3
            logic [1:0] bank;
            // register within the bank
            logic [1:0] rnum;
            // byte lane within the register
            logic [1:0] lane;
        } acc;
        struct packed {
            // F for pointer registers
            logic [3:0] tag;
            // pointer register 0..3
            logic [1:0] pnum;
            // byte lane, same bits as acc.lane
            logic [1:0] lane;
        } ptr;
    } reg_code_t;

    // write width on the external register port
    // start lane is aligned down to the size
    typedef enum logic [1:0] {
        WSIZE_BYTE = 2'd0,
        WSIZE_WORD = 2'd1,
        WSIZE_LONG = 2'd2
    } wsize_t;

endpackage

/* addr_pkg.sv */
package addr_pkg;

    // register indirect addressing modes
    typedef enum logic [1:0] {
        MODE_PLAIN   = 2'd0,
        MODE_POSTINC = 2'd1,
        MODE_PREDEC  = 2'd2,
        MODE_OFFSET  = 2'd3
    } addr_mode_t;

    // pointer step size code, as carried by the decoder
    typedef logic [1:0] step_t;

    localparam step_t STEP_WORD = 2'd1;
    localparam step_t STEP_LONG = 2'd2;

    // step code to byte count
    // 1 -> 2 bytes, 2 -> 4 bytes, 0 and 3 -> 1 byte
    function automatic logic [2:0] step_bytes(input step_t step);
        case (step)
            STEP_WORD: return 3'd2;
            STEP_LONG: return 3'd4;
            default:   return 3'd1;
        endcase
    endfunction

endpackage

/* reg_port_if.sv */
interface reg_port_if;
    import regs_pkg::*;

    // pointer register code, also the pointer write target
    reg_code_t   src_code;
    // offset register code for the offset mode
    reg_code_t   aux_code;
    // combinational read data from the register file
    logic [31:0] src_val;
    logic [31:0] aux_val;
    // whole register write of the pointer named by src_code
    logic        ptr_we;
    logic [31:0] ptr_wdata;

    // addresser side
    modport addr (
        output src_code, aux_code, ptr_we, ptr_wdata,
        input  src_val, aux_val
    );

    // register file side
    modport regs (
        input  src_code, aux_code, ptr_we, ptr_wdata,
        output src_val, aux_val
    );

endinterface

/* cpu_regs.sv */
module cpu_regs (
    input  logic                clk,
    input  logic                reset,
    // register file pointer, selects the current bank
    input  logic [1:0]          rfp,
    // sized write port
    input  logic                reg_we,
    input  regs_pkg::reg_code_t reg_wcode,
    input  regs_pkg::wsize_t    reg_wsize,
    input  logic [31:0]         reg_wdata,
    // external read port
    input  regs_pkg::reg_code_t rd_code,
    output logic [31:0]         rd_value,
    // addresser access
    reg_port_if.regs            port
);
    import regs_pkg::*;

    // 4 banks x 4 regs x 4 bytes
    logic [7:0] acc_bytes [0:63];
    // 4 pointers x 4 bytes
    logic [7:0] ptr_bytes [0:15];

    // resolved codes for both write paths
    reg_code_t   wr_norm;
    reg_code_t   pw_norm;
    // lanes hit by the sized write, data replicated per lane
    logic [3:0]  wr_lanes;
    logic [31:0] wr_data;

    // turn the E and D tags into a plain bank number
    // any other code passes through untouched
    function automatic reg_code_t normalise(input reg_code_t code);
        reg_code_t n;
        n = code;
        if (code.ptr.tag == TAG_CUR) begin
            n.acc.page = 2'd0;
            n.acc.bank = rfp;
        end else if (code.ptr.tag == TAG_PREV) begin
            n.acc.page = 2'd0;
            // 2-bit subtract gives the wrap from bank 0 to 3
            n.acc.bank = rfp - 2'd1;
        end
        return n;
    endfunction

    // whole 32-bit register named by a code, lane bits ignored
    function automatic logic [31:0] read_reg(input reg_code_t code);
        reg_code_t n;
        n = normalise(code);
        if (n.ptr.tag == TAG_PTR) begin
            return {ptr_bytes[{n.ptr.pnum, 2'd3}], ptr_bytes[{n.ptr.pnum, 2'd2}],
                    ptr_bytes[{n.ptr.pnum, 2'd1}], ptr_bytes[{n.ptr.pnum, 2'd0}]};
        end
        return {acc_bytes[{n.acc.bank, n.acc.rnum, 2'd3}],
                acc_bytes[{n.acc.bank, n.acc.rnum, 2'd2}],
                acc_bytes[{n.acc.bank, n.acc.rnum, 2'd1}],
                acc_bytes[{n.acc.bank, n.acc.rnum, 2'd0}]};
    endfunction

    // three read ports, no latency
    always_comb begin
        rd_value     = read_reg(rd_code);
        port.src_val = read_reg(port.src_code);
        port.aux_val = read_reg(port.aux_code);
    end

    // sized write decode
    always_comb begin
        wr_norm = normalise(reg_wcode);
        pw_norm = normalise(port.src_code);
        case (reg_wsize)
            WSIZE_BYTE: begin
                wr_lanes = 4'b0001 << wr_norm.acc.lane;
                wr_data  = {4{reg_wdata[7:0]}};
            end
            WSIZE_WORD: begin
                // word sits on lanes 1:0 or 3:2
                wr_lanes = 4'b0011 << {wr_norm.acc.lane[1], 1'b0};
                wr_data  = {2{reg_wdata[15:0]}};
            end
            default: begin
                wr_lanes = 4'b1111;
                wr_data  = reg_wdata;
            end
        endcase
    end

    // pointer write first, sized write after it
    // on a shared byte the later assignment wins, so reg_we has priority
    // no writes taken while reset is high
    always_ff @(posedge clk) begin
        if (!reset && port.ptr_we) begin
            for (int l = 0; l < 4; l++) begin
                if (pw_norm.ptr.tag == TAG_PTR) begin
                    ptr_bytes[{pw_norm.ptr.pnum, 2'(l)}] <= port.ptr_wdata[8*l +: 8];
                end else begin
                    acc_bytes[{pw_norm.acc.bank, pw_norm.acc.rnum, 2'(l)}] <=
                        port.ptr_wdata[8*l +: 8];
                end
            end
        end
        if (!reset && reg_we) begin
            for (int l = 0; l < 4; l++) begin
                if (wr_lanes[l]) begin
                    if (wr_norm.ptr.tag == TAG_PTR) begin
                        ptr_bytes[{wr_norm.ptr.pnum, 2'(l)}] <= wr_data[8*l +: 8];
                    end else begin
                        acc_bytes[{wr_norm.acc.bank, wr_norm.acc.rnum, 2'(l)}] <=
                            wr_data[8*l +: 8];
                    end
                end
            end
        end
    end

endmodule

/* idx_addresser.sv */
module idx_addresser #(
    parameter int ADDR_W = 24
) (
    input  logic                 clk,
    input  logic                 reset,
    // command from the decoder
    input  logic                 start,
    input  addr_pkg::addr_mode_t cmd_mode,
    input  regs_pkg::reg_code_t  cmd_code,
    input  regs_pkg::reg_code_t  cmd_aux,
    input  addr_pkg::step_t      cmd_step,
    output logic                 busy,
    output logic                 done,
    output logic [31:0]          rd_data,
    output logic [ADDR_W-1:0]    ea_out,
    // wishbone classic read master
    output logic [ADDR_W-1:0]    wb_adr,
    output logic                 wb_cyc,
    output logic                 wb_stb,
    output logic                 wb_we,
    input  logic [31:0]          wb_dat_i,
    input  logic                 wb_ack,
    // register file access
    reg_port_if.addr             regs
);
    import regs_pkg::*;
    import addr_pkg::*;

    // sequencer states
    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_BUS    = 2'd1;
    localparam logic [1:0] ST_FINISH = 2'd2;

    logic [1:0]        state;
    logic              accept;
    // latched pointer code, needed for the write one cycle later
    reg_code_t         code_q;
    logic [ADDR_W-1:0] ea_q;
    logic [31:0]       ptr_wdata_q;
    logic              ptr_we_q;

    // address arithmetic, accept cycle only
    logic [31:0]       step_val;
    logic [31:0]       off_val;
    logic [31:0]       ea_next;
    logic [31:0]       ptr_next;

    // start only counts while not busy
    // finish counts as not busy, back to back commands are fine
    assign accept = start && !busy;

    // outputs straight from the state
    assign busy   = (state == ST_BUS);
    assign done   = (state == ST_FINISH);
    assign wb_cyc = (state == ST_BUS);
    assign wb_stb = (state == ST_BUS);
    // reads only
    assign wb_we  = 1'b0;
    assign wb_adr = ea_q;
    assign ea_out = ea_q;

    // pointer code from the command port while idle, latched copy later
    assign regs.src_code  = busy ? code_q : cmd_code;
    assign regs.aux_code  = cmd_aux;
    assign regs.ptr_we    = ptr_we_q;
    assign regs.ptr_wdata = ptr_wdata_q;

    always_comb begin
        step_val = {29'd0, step_bytes(cmd_step)};
        // low half of the aux register, sign extended
        off_val  = {{16{regs.aux_val[15]}}, regs.aux_val[15:0]};
        ea_next  = regs.src_val;
        ptr_next = regs.src_val;
        case (cmd_mode)
            MODE_POSTINC: begin
                // access at the old pointer, bump afterwards
                ptr_next = regs.src_val + step_val;
            end
            MODE_PREDEC: begin
                ea_next  = regs.src_val - step_val;
                ptr_next = ea_next;
            end
            MODE_OFFSET: begin
                ea_next = regs.src_val + off_val;
            end
            default: begin
                // plain, pointer as is
                ea_next = regs.src_val;
            end
        endcase
    end

    // control state
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ST_IDLE;
            ptr_we_q <= 1'b0;
        end else begin
            // one write pulse in the first bus cycle
            ptr_we_q <= accept && (cmd_mode == MODE_POSTINC || cmd_mode == MODE_PREDEC);
            case (state)
                ST_BUS: begin
                    // hold everything until the slave acks
                    if (wb_ack) begin
                        state <= ST_FINISH;
                    end
                end
                default: begin
                    state <= accept ? ST_BUS : ST_IDLE;
                end
            endcase
        end
    end

    // payload, loaded on accept and on ack
    always_ff @(posedge clk) begin
        if (accept) begin
            code_q      <= cmd_code;
            ea_q        <= ea_next[ADDR_W-1:0];
            ptr_wdata_q <= ptr_next;
        end
        if (state == ST_BUS && wb_ack) begin
            rd_data <= wb_dat_i;
        end
    end

endmodule

/* regaddr_top.sv */
module regaddr_top #(
    parameter int ADDR_W = 24
) (
    input  logic                 clk,
    input  logic                 reset,
    // register file
    input  logic [1:0]           rfp,
    input  logic                 reg_we,
    input  regs_pkg::reg_code_t  reg_wcode,
    input  regs_pkg::wsize_t     reg_wsize,
    input  logic [31:0]          reg_wdata,
    input  regs_pkg::reg_code_t  rd_code,
    output logic [31:0]          rd_value,
    // addresser command port
    input  logic                 start,
    input  addr_pkg::addr_mode_t cmd_mode,
    input  regs_pkg::reg_code_t  cmd_code,
    input  regs_pkg::reg_code_t  cmd_aux,
    input  addr_pkg::step_t      cmd_step,
    output logic                 busy,
    output logic                 done,
    output logic [31:0]          rd_data,
    output logic [ADDR_W-1:0]    ea_out,
    // wishbone memory port
    output logic [ADDR_W-1:0]    wb_adr,
    output logic                 wb_cyc,
    output logic                 wb_stb,
    output logic                 wb_we,
    input  logic [31:0]          wb_dat_i,
    input  logic                 wb_ack
);

    // addresser to register file link
    reg_port_if u_reg_port ();

    cpu_regs u_cpu_regs (
        .clk       (clk),
        .reset     (reset),
        .rfp       (rfp),
        .reg_we    (reg_we),
        .reg_wcode (reg_wcode),
        .reg_wsize (reg_wsize),
        .reg_wdata (reg_wdata),
        .rd_code   (rd_code),
        .rd_value  (rd_value),
        .port      (u_reg_port.regs)
    );

    idx_addresser #(
        .ADDR_W (ADDR_W)
    ) u_idx_addresser (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .cmd_mode (cmd_mode),
        .cmd_code (cmd_code),
        .cmd_aux  (cmd_aux),
        .cmd_step (cmd_step),
        .busy     (busy),
        .done     (done),
        .rd_data  (rd_data),
        .ea_out   (ea_out),
        .wb_adr   (wb_adr),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_dat_i (wb_dat_i),
        .wb_ack   (wb_ack),
        .regs     (u_reg_port.addr)
    );

endmodule

/* regaddr_sva.sv */
module regaddr_sva #(
    parameter int ADDR_W = 24
) (
    input logic              clk,
    input logic              reset,
    input logic              wb_cyc,
    input logic              wb_stb,
    input logic              wb_ack,
    input logic              done,
    input logic [ADDR_W-1:0] wb_adr
);

    // strobe only inside a cycle
    a_stb_cyc: assert property (@(posedge clk) disable iff (reset) wb_stb |-> wb_cyc)
        else $error("wb_stb high without wb_cyc");

    // request and address held until the slave acks
    a_hold: assert property (@(posedge clk) disable iff (reset)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr))
        else $error("wb_stb or wb_adr changed before wb_ack");

    // done one cycle after the ack, and only then
    a_done: assert property (@(posedge clk) disable iff (reset) wb_stb && wb_ack |=> done)
        else $error("done missing one cycle after wb_ack");
    a_done_src: assert property (@(posedge clk) disable iff (reset)
        done |-> $past(wb_stb && wb_ack))
        else $error("done without a preceding wb_ack");

    // bus idle coming out of reset
    a_reset: assert property (@(posedge clk) reset |=> !wb_cyc && !done)
        else $error("wb_cyc or done high after reset");

endmodule

bind idx_addresser regaddr_sva #(.ADDR_W(ADDR_W)) u_regaddr_sva (
    .clk    (clk),
    .reset  (reset),
    .wb_cyc (wb_cyc),
    .wb_stb (wb_stb),
    .wb_ack (wb_ack),
    .done   (done),
    .wb_adr (wb_adr)
);

/* tb_top.sv */
module tb_top;
    import regs_pkg::*;
    import addr_pkg::*;

    localparam int ADDR_W = 24;
    // cycles allowed for any single wait
    localparam int WAIT_MAX = 50;

    logic              clk = 1'b0;
    logic              reset = 1'b1;
    logic [1:0]        rfp = 2'd0;
    logic              reg_we = 1'b0;
    reg_code_t         reg_wcode = 8'h00;
    wsize_t            reg_wsize = WSIZE_LONG;
    logic [31:0]       reg_wdata = 32'd0;
    reg_code_t         rd_code = 8'h00;
    logic              start = 1'b0;
    addr_mode_t        cmd_mode = MODE_PLAIN;
    reg_code_t         cmd_code = 8'h00;
    reg_code_t         cmd_aux = 8'h00;
    step_t             cmd_step = 2'd0;
    logic [31:0]       wb_dat_i = 32'd0;
    logic              wb_ack = 1'b0;
    logic [31:0]       rd_value, rd_data;
    logic              busy, done, wb_cyc, wb_stb, wb_we;
    logic [ADDR_W-1:0] ea_out, wb_adr;

    // reference copy, slots 0..15 are acc {bank, reg}, 16..19 pointers
    logic [31:0] model_q [0:19];
    int          err_val = 0;
    int          err_proto = 0;
    int          accepted = 0;
    int          done_seen = 0;
    // wait states for the next bus cycle, set by the stimulus
    int          ack_delay = 0;
    int          wait_left = 0;
    logic        in_cycle = 1'b0;

    regaddr_top #(.ADDR_W(ADDR_W)) u_regaddr_top (.*);

    always #50 clk = ~clk;

    // every done pulse, compared with accepted commands at the end
    always @(posedge clk) begin
        if (!reset && done) begin
            done_seen++;
        end
    end

    // memory slave, one ack after ack_delay wait cycles
    always @(negedge clk) begin
        if (reset) begin
            wb_ack   = 1'b0;
            in_cycle = 1'b0;
        end else if (wb_ack) begin
            wb_ack = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            // read only master, write enable stays low
            check_we(wb_we);
            if (!in_cycle) begin
                in_cycle  = 1'b1;
                wait_left = ack_delay;
            end
            if (wait_left == 0) begin
                wb_ack   = 1'b1;
                wb_dat_i = mem_word(wb_adr);
                in_cycle = 1'b0;
            end else begin
                wait_left--;
            end
        end
    end

    // memory contents, mixed from the full address
    function automatic logic [31:0] mem_word(input logic [ADDR_W-1:0] a);
        logic [31:0] x;
        x = 32'(a) * 32'h9e37_79b1;
        return x ^ {x[15:0], x[31:16]} ^ 32'h5ac3_0f96;
    endfunction

    // model slot for a code, E and D follow rfp, F is the pointer group
    function automatic int slot(input reg_code_t c);
        logic [1:0] bank;
        if (c[7:4] == TAG_PTR) return 16 + int'(c[3:2]);
        if (c[7:4] == TAG_CUR) bank = rfp;
        else if (c[7:4] == TAG_PREV) bank = rfp - 2'd1;
        else bank = c[5:4];
        return int'({bank, c[3:2]});
    endfunction

    // merge a sized write into the model
    function automatic void model_write(input reg_code_t c, input wsize_t sz,
                                        input logic [31:0] d);
        logic [31:0] mask;
        logic [31:0] val;
        int          sh;
        case (sz)
            WSIZE_BYTE: begin
                sh   = 8 * int'(c[1:0]);
                mask = 32'h0000_00ff << sh;
                val  = {24'd0, d[7:0]} << sh;
            end
            WSIZE_WORD: begin
                // upper lane bit picks the half
                sh   = 16 * int'(c[1]);
                mask = 32'h0000_ffff << sh;
                val  = {16'd0, d[15:0]} << sh;
            end
            default: begin
                mask = 32'hffff_ffff;
                val  = d;
            end
        endcase
        model_q[slot(c)] = (model_q[slot(c)] & ~mask) | (val & mask);
    endfunction

    task automatic check_reg(input reg_code_t c, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR rd_value code=%h got=%h exp=%h", c, got, exp);
            err_val++;
        end
    endtask

    task automatic check_addr(input logic [ADDR_W-1:0] got, input logic [ADDR_W-1:0] exp);
        if (got !== exp) begin
            $display("ERR ea_out got=%h exp=%h", got, exp);
            err_val++;
        end
    endtask

    task automatic check_data(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR rd_data got=%h exp=%h", got, exp);
            err_val++;
        end
    endtask

    task automatic check_we(input logic got);
        if (got !== 1'b0) begin
            $display("ERR wb_we got=%h exp=%h", got, 1'b0);
            err_val++;
        end
    endtask

    // called and returning on a falling edge
    task automatic write_reg(input reg_code_t c, input wsize_t sz, input logic [31:0] d);
        reg_we    = 1'b1;
        reg_wcode = c;
        reg_wsize = sz;
        reg_wdata = d;
        model_write(c, sz, d);
        @(negedge clk);
        reg_we = 1'b0;
    endtask

    task automatic read_expect(input reg_code_t c, input logic [31:0] exp);
        rd_code = c;
        @(negedge clk);
        check_reg(c, rd_value, exp);
    endtask

    // one command on pointer p, poke adds a second start while busy
    task automatic run_cmd(input addr_mode_t mode, input logic [1:0] p, input reg_code_t aux,
                           input step_t st, input bit poke);
        logic [31:0]       old_ptr;
        logic [31:0]       aux_w;
        logic [31:0]       step_n;
        logic [31:0]       ea32;
        logic [31:0]       new_ptr;
        logic [ADDR_W-1:0] exp_ea;
        int                cnt;
        old_ptr = model_q[16 + int'(p)];
        aux_w   = model_q[slot(aux)];
        step_n  = (st == 2'd1) ? 32'd2 : (st == 2'd2) ? 32'd4 : 32'd1;
        ea32    = old_ptr;
        new_ptr = old_ptr;
        if (mode == MODE_POSTINC) new_ptr = old_ptr + step_n;
        if (mode == MODE_PREDEC) begin
            ea32    = old_ptr - step_n;
            new_ptr = ea32;
        end
        if (mode == MODE_OFFSET) ea32 = old_ptr + {{16{aux_w[15]}}, aux_w[15:0]};
        exp_ea    = ea32[ADDR_W-1:0];
        ack_delay = int'($urandom_range(3, 0));
        cmd_mode  = mode;
        cmd_code  = {TAG_PTR, p, 2'($urandom())};
        cmd_aux   = aux;
        cmd_step  = st;
        start     = 1'b1;
        accepted++;
        @(negedge clk);
        start = 1'b0;
        if (poke) begin
            if (!busy) begin
                $display("busy did not rise after an accepted start");
                err_proto++;
            end
            // must be dropped, would bump the next pointer
            cmd_mode = MODE_POSTINC;
            cmd_code = {TAG_PTR, p + 2'd1, 2'd0};
            cmd_step = STEP_LONG;
            start    = 1'b1;
            @(negedge clk);
            start = 1'b0;
        end
        cnt = 0;
        while (!done && cnt < WAIT_MAX) begin
            @(negedge clk);
            cnt++;
        end
        if (!done) begin
            $display("timeout waiting for done after a start");
            err_proto++;
        end else begin
            check_addr(ea_out, exp_ea);
            check_data(rd_data, mem_word(exp_ea));
        end
        model_q[16 + int'(p)] = new_ptr;
    endtask

    initial begin
        logic [31:0] r;
        reg_code_t   c;
        logic [1:0]  rn;
        void'($urandom(26935));
        repeat (10) @(negedge clk);
        reset = 1'b0;
        // known value in every register first
        for (int i = 0; i < 20; i++) begin
            c = (i < 16) ? {2'b00, 4'(i), 2'b00} : {TAG_PTR, 2'(i), 2'b00};
            write_reg(c, WSIZE_LONG, $urandom());
        end
        // sized writes on random codes, read back it and another one
        for (int i = 0; i < 40; i++) begin
            r = $urandom();
            c = r[7:0];
            write_reg(c, wsize_t'((r[9:8] == 2'd3) ? 2'd2 : r[9:8]), $urandom());
            read_expect(c, model_q[slot(c)]);
            c = r[23:16];
            read_expect(c, model_q[slot(c)]);
        end
        // current and previous bank aliases, first pass wraps 0 to 3
        for (int i = 0; i < 40; i++) begin
            rfp = (i == 0) ? 2'd0 : 2'($urandom());
            rn  = 2'($urandom());
            read_expect({TAG_CUR, rn, 2'd0}, model_q[{rfp, rn}]);
            read_expect({TAG_PREV, rn, 2'd0}, model_q[{rfp - 2'd1, rn}]);
        end
        // all four modes in turn, offset sign alternates
        for (int i = 0; i < 60; i++) begin
            r  = $urandom();
            c  = {2'b00, r[3:0], 2'b00};
            rn = r[21:20];
            write_reg(c, WSIZE_WORD, {16'd0, i[2], r[18:4]});
            run_cmd(addr_mode_t'(2'(i)), rn, c, r[23:22], 1'b0);
            read_expect({TAG_PTR, rn, 2'd0}, model_q[16 + int'(rn)]);
        end
        // start while busy, no pointer may move
        for (int i = 0; i < 20; i++) begin
            r = $urandom();
            run_cmd(addr_mode_t'(r[1:0]), r[3:2], r[15:8], r[5:4], 1'b1);
            for (int k = 0; k < 4; k++) begin
                read_expect({TAG_PTR, 2'(k), 2'd0}, model_q[16 + k]);
            end
        end
        repeat (5) @(negedge clk);
        if (done_seen != accepted) begin
            $display("done pulsed %0d times for %0d accepted commands", done_seen, accepted);
            err_proto++;
        end
        $display("errors: %0d value, %0d protocol", err_val, err_proto);
        if (err_val == 0 && err_proto == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* sim.f */
regs_pkg.sv
addr_pkg.sv
reg_port_if.sv
cpu_regs.sv
idx_addresser.sv
regaddr_top.sv
regaddr_sva.sv
tb_top.sv

/* run.sh */
#!/usr/bin/env bash
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --top-module tb_top -f sim.f -o tb_top_sim \
    && ./obj_dir/tb_top_sim | tee sim.log \
    || echo "build or simulation did not complete"
grep -q '\*\*\* PASSED \*\*\*' sim.log 2>/dev/null \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }
